/* bench/adc_golden.txt */
// header: record count, frame count. records: {sync,ovr} di di_d dq dq_d
// frames: i, i_d, q, q_d words (slot 0 low byte), then {sync[3:0], ovr[1:0]}
3b 0c
00eeeeeeee 00eeeeeeee 00eeeeeeee
021014181c 001115191d 0012161a1e 0013171b1f
002024282c 012125292d 0022262a2e 0023272b2f
023034383c 003135393d 0032363a3e 0033373b3f
004044484c 004145494d 0042464a4e 0143474b4f
005054585c 005155595d 0052565a5e 0053575b5f
006064686c 006165696d 0262666a6e 0063676b6f
017074787c 007175797d 0172767a7e 0073777b7f
008084888c 008185898d 0082868a8e 0083878b8f
009094989c 009195999d 0192969a9e 0093979b9f
00a0a4a8ac 00a1a5a9ad 00a2a6aaae 00a3a7abaf
00b0b4b8bc 00b1b5b9bd 00b2b6babe 00b3b7bbbf
00c0c4c8cc 00c1c5c9cd 00c2c6cace 00c3c7cbcf
00d0d4d8dc 00d1d5d9dd 00d2d6dade 00d3d7dbdf
00e0e4e8ec 00e1e5e9ed 00e2e6eaee 00e3e7ebef
13121110 17161514 1b1a1918 1f1e1d1c 04
23222120 27262524 2b2a2928 2f2e2d2c 01
33323130 37363534 3b3a3938 3f3e3d3c 04
43424140 47464544 4b4a4948 4f4e4d4c 02
53525150 57565554 5b5a5958 5f5e5d5c 00
63626160 67666564 6b6a6968 6f6e6d6c 10
73727170 77767574 7b7a7978 7f7e7d7c 03
83828180 87868584 8b8a8988 8f8e8d8c 00
93929190 97969594 9b9a9998 9f9e9d9c 02
a3a2a1a0 a7a6a5a4 abaaa9a8 afaeadac 00
b3b2b1b0 b7b6b5b4 bbbab9b8 bfbebdbc 00
c3c2c1c0 c7c6c5c4 cbcac9c8 cfcecdcc 00

/* bench/tb_adc_capture.sv */
/*
 * ADC capture testbench
 * replays the golden stimulus records into the capture top level,
 * returns credits after pseudo-random delays and checks each
 * delivered frame against the golden frames, including overflow
 */
`timescale 1ns/10ps

module tb_adc_capture;
  import adc_pkg::*;

  localparam int GOLD_SIZE    = 128;  // golden entries for header, records and frames
  localparam int FRAME_ENTRY  = 5;    // i, i_d, q, q_d, status
  localparam int CREDITS_BACK = 10;   // credits returned after stimulus
  localparam int EXTRA_FRAMES = 2;    // idle frames expected after the golden ones

  logic                    adc_clk;
  logic                    dcm_reset;
  sample_t                 adc_di;
  sample_t                 adc_di_d;
  sample_t                 adc_dq;
  sample_t                 adc_dq_d;
  logic                    adc_sync;
  logic                    adc_overrange;
  logic                    user_credit;
  lane_word_t              user_i;
  lane_word_t              user_i_d;
  lane_word_t              user_q;
  lane_word_t              user_q_d;
  logic [DESER_FACTOR-1:0] user_sync;
  logic [OVR_GROUPS-1:0]   user_overrange;
  logic                    user_data_valid;
  logic                    user_overflow;

  logic [39:0] gold [GOLD_SIZE];  // header, stimulus records, expected frames
  int          rec_cnt;
  int          frm_cnt;
  int          frm_base;          // index of first expected frame entry
  int          value_errs;
  int          other_errs;
  int          frames_seen;
  int          credits_back;
  bit          in_reset;
  bit          stim_done;
  bit          sync_seen;
  bit          ovf_seen;
  logic [31:0] lfsr;

  adc_capture_top u_adc_capture_top (
    .adc_clk         (adc_clk),
    .dcm_reset       (dcm_reset),
    .adc_di          (adc_di),
    .adc_di_d        (adc_di_d),
    .adc_dq          (adc_dq),
    .adc_dq_d        (adc_dq_d),
    .adc_sync        (adc_sync),
    .adc_overrange   (adc_overrange),
    .user_credit     (user_credit),
    .user_i          (user_i),
    .user_i_d        (user_i_d),
    .user_q          (user_q),
    .user_q_d        (user_q_d),
    .user_sync       (user_sync),
    .user_overrange  (user_overrange),
    .user_data_valid (user_data_valid),
    .user_overflow   (user_overflow)
  );

  // 100 ns clock
  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  // fibonacci lfsr on taps 32 22 2 1 stepped once per bit
  function automatic int random_bits(int n);
    int v;
    int k;
    v = 0;
    for (k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  task automatic apply_record(input logic [39:0] rec);
    adc_sync      = rec[33];
    adc_overrange = rec[32];
    adc_di        = rec[31:24];
    adc_di_d      = rec[23:16];
    adc_dq        = rec[15:8];
    adc_dq_d      = rec[7:0];
    if (rec[33]) begin
      sync_seen = 1'b1;  // word boundary starts here
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    assert (act === exp) else begin
      value_errs++;
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // golden frames come first and idle all-zero frames after them
  task automatic check_frame();
    int b;
    frames_seen++;
    assert (frames_seen <= CREDIT_INIT + credits_back) else begin
      other_errs++;
      $display("%0t ns: frame %0d delivered without a credit", $time, frames_seen);
    end
    if (frames_seen <= frm_cnt) begin
      b = frm_base + FRAME_ENTRY * (frames_seen - 1);
      compare_value("user_i", gold[b][31:0], user_i);
      compare_value("user_i_d", gold[b+1][31:0], user_i_d);
      compare_value("user_q", gold[b+2][31:0], user_q);
      compare_value("user_q_d", gold[b+3][31:0], user_q_d);
      compare_value("user_sync", {28'b0, gold[b+4][5:2]}, {28'b0, user_sync});
      compare_value("user_overrange", {30'b0, gold[b+4][1:0]}, {30'b0, user_overrange});
    end else begin
      // dropped frames must not show up here
      compare_value("user_i", 32'h0, user_i);
      compare_value("user_i_d", 32'h0, user_i_d);
      compare_value("user_q", 32'h0, user_q);
      compare_value("user_q_d", 32'h0, user_q_d);
    end
  endtask

  // --------------------------------------------------
  // stimulus and end of run
  // --------------------------------------------------
  initial begin
    int i;
    dcm_reset     = 1'b1;
    in_reset      = 1'b1;
    user_credit   = 1'b0;
    apply_record(40'h0);
    lfsr          = 32'hea34659d;
    value_errs    = 0;
    other_errs    = 0;
    frames_seen   = 0;
    credits_back  = 0;
    $readmemh("bench/adc_golden.txt", gold);
    rec_cnt  = int'(gold[0]);
    frm_cnt  = int'(gold[1]);
    frm_base = 2 + rec_cnt;
    repeat (5) @(posedge adc_clk);
    #1;
    dcm_reset = 1'b0;
    in_reset  = 1'b0;
    for (i = 0; i < rec_cnt; i++) begin
      apply_record(gold[2+i]);
      @(posedge adc_clk);
      #1;
    end
    apply_record(40'h0);  // idle lanes from here on
    stim_done = 1'b1;
    wait (frames_seen >= frm_cnt + EXTRA_FRAMES);
    repeat (4) @(posedge adc_clk);
    assert (user_overflow) else begin
      other_errs++;
      $display("user_overflow never rose although frames were dropped");
    end
    $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // no credits during stimulus so the fifo overflows
  initial begin
    int dly;
    wait (stim_done);
    repeat (2) @(posedge adc_clk);
    while (credits_back < CREDITS_BACK) begin
      dly = 1 + random_bits(2);  // 1..4 cycles
      repeat (dly) @(posedge adc_clk);
      #1 user_credit = 1'b1;
      @(posedge adc_clk);
      credits_back++;  // pulse taken at this edge
      #1 user_credit = 1'b0;
    end
  end

  // output monitor on the falling edge
  always @(negedge adc_clk) begin
    if (!in_reset) begin
      if (!sync_seen) begin
        assert (!user_data_valid && !user_overflow) else begin
          other_errs++;
          $display("%0t ns: output active before the first sync", $time);
        end
      end
      if (ovf_seen) begin
        assert (user_overflow) else begin
          other_errs++;
          $display("%0t ns: user_overflow fell before reset", $time);
        end
      end
      if (user_overflow) begin
        ovf_seen = 1'b1;
      end
      if (user_data_valid) begin
        check_frame();
      end
    end
  end

  // watchdog sized from the record count
  initial begin
    #1;
    if (rec_cnt > 0) begin
      #(2 * rec_cnt * 100 + 2000 - 1);
      $display("watchdog expired, %0d frames seen", frames_seen);
    end else begin
      $display("golden file gave no stimulus records");
    end
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* flist.f */
rtl/adc_pkg.sv
rtl/adc_sample_deser.sv
rtl/adc_status_capture.sv
rtl/adc_frame_buffer.sv
rtl/adc_capture_top.sv
bench/tb_adc_capture.sv

/* rtl/adc_capture_top.sv */
/*
 * ADC capture top level
 * sample deserializer and status capture side by side, both feeding
 * the credit-controlled frame buffer
 */
`timescale 1ns/10ps

module adc_capture_top (
  input  logic                             adc_clk,
  input  logic                             dcm_reset,
  input  adc_pkg::sample_t                 adc_di,
  input  adc_pkg::sample_t                 adc_di_d,
  input  adc_pkg::sample_t                 adc_dq,
  input  adc_pkg::sample_t                 adc_dq_d,
  input  logic                             adc_sync,
  input  logic                             adc_overrange,
  input  logic                             user_credit,
  output adc_pkg::lane_word_t              user_i,
  output adc_pkg::lane_word_t              user_i_d,
  output adc_pkg::lane_word_t              user_q,
  output adc_pkg::lane_word_t              user_q_d,
  output logic [adc_pkg::DESER_FACTOR-1:0] user_sync,
  output logic [adc_pkg::OVR_GROUPS-1:0]   user_overrange,
  output logic                             user_data_valid,
  output logic                             user_overflow
);
  import adc_pkg::*;

  // ------------------------------------------------
  // internal wiring
  // ------------------------------------------------
  lane_word_t              i_word;
  lane_word_t              i_d_word;
  lane_word_t              q_word;
  lane_word_t              q_d_word;
  logic                    word_valid;
  logic                    slot_last;  // closes the status group
  logic [DESER_FACTOR-1:0] sync_bits;
  logic [OVR_GROUPS-1:0]   ovr_bits;

  adc_sample_deser u_sample_deser (
    .adc_clk    (adc_clk),
    .dcm_reset  (dcm_reset),
    .adc_di     (adc_di),
    .adc_di_d   (adc_di_d),
    .adc_dq     (adc_dq),
    .adc_dq_d   (adc_dq_d),
    .adc_sync   (adc_sync),
    .i_word     (i_word),
    .i_d_word   (i_d_word),
    .q_word     (q_word),
    .q_d_word   (q_d_word),
    .word_valid (word_valid),
    .slot_last  (slot_last)
  );

  adc_status_capture u_status_capture (
    .adc_clk       (adc_clk),
    .dcm_reset     (dcm_reset),
    .adc_sync      (adc_sync),
    .adc_overrange (adc_overrange),
    .slot_last     (slot_last),
    .sync_bits     (sync_bits),
    .ovr_bits      (ovr_bits)
  );

  adc_frame_buffer u_frame_buffer (
    .adc_clk         (adc_clk),
    .dcm_reset       (dcm_reset),
    .i_word          (i_word),
    .i_d_word        (i_d_word),
    .q_word          (q_word),
    .q_d_word        (q_d_word),
    .sync_bits       (sync_bits),
    .ovr_bits        (ovr_bits),
    .word_valid      (word_valid),
    .user_credit     (user_credit),
    .user_i          (user_i),
    .user_i_d        (user_i_d),
    .user_q          (user_q),
    .user_q_d        (user_q_d),
    .user_sync       (user_sync),
    .user_overrange  (user_overrange),
    .user_data_valid (user_data_valid),
    .user_overflow   (user_overflow)
  );

endmodule

/* rtl/adc_frame_buffer.sv */
/*
 * ADC frame buffer
 * packs lane words and status into one frame, queues frames in a
 * small circular FIFO and hands them out under credit flow control.
 * Frames arriving at a full FIFO are dropped and flagged
 */
`timescale 1ns/10ps

module adc_frame_buffer (
  input  logic                             adc_clk,
  input  logic                             dcm_reset,
  input  adc_pkg::lane_word_t              i_word,
  input  adc_pkg::lane_word_t              i_d_word,
  input  adc_pkg::lane_word_t              q_word,
  input  adc_pkg::lane_word_t              q_d_word,
  input  logic [adc_pkg::DESER_FACTOR-1:0] sync_bits,
  input  logic [adc_pkg::OVR_GROUPS-1:0]   ovr_bits,
  input  logic                             word_valid,
  input  logic                             user_credit,
  output adc_pkg::lane_word_t              user_i,
  output adc_pkg::lane_word_t              user_i_d,
  output adc_pkg::lane_word_t              user_q,
  output adc_pkg::lane_word_t              user_q_d,
  output logic [adc_pkg::DESER_FACTOR-1:0] user_sync,
  output logic [adc_pkg::OVR_GROUPS-1:0]   user_overrange,
  output logic                             user_data_valid,
  output logic                             user_overflow
);
  import adc_pkg::*;

  localparam logic [CNT_W-1:0]    FULL_CNT   = CNT_W'(FIFO_DEPTH);
  localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(CREDIT_INIT);

  logic [FRAME_W-1:0]  frame_in;
  logic [FRAME_W-1:0]  frame_q;   // output frame register
  logic [FRAME_W-1:0]  mem [FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    fill_cnt;
  logic [CREDIT_W-1:0] credits;
  logic [CREDIT_W-1:0] credits_left;  // after this cycle's frame
  logic                fifo_empty;
  logic                fifo_full;
  logic                have_credit;
  logic                pop;
  logic                bypass;
  logic                push;
  logic                drop;
  logic                send;

  // status bits on top of the four lane words
  assign frame_in = {sync_bits, ovr_bits, q_word, q_d_word, i_word, i_d_word};

  // ------------------------------------------------
  // flow decisions
  // ------------------------------------------------
  assign fifo_empty  = (fill_cnt == '0);
  assign fifo_full   = (fill_cnt == FULL_CNT);
  assign have_credit = (credits != '0);
  assign pop         = !fifo_empty && have_credit;
  assign bypass      = fifo_empty && have_credit && word_valid;  // straight to output
  assign push        = word_valid && !bypass && !fifo_full;
  assign drop        = word_valid && fifo_full;  // a full fifo drops even while popping
  assign send        = pop || bypass;
  assign credits_left = credits - CREDIT_W'(send);

  // frame storage and output register
  always_ff @(posedge adc_clk) begin
    if (push) begin
      mem[wr_ptr] <= frame_in;
    end
    if (send) begin
      frame_q <= pop ? mem[rd_ptr] : frame_in;  // oldest first
    end
  end

  // ------------------------------------------------
  // pointers, fill level, credits
  // ------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      fill_cnt        <= '0;
      credits         <= CREDIT_MAX;
      user_data_valid <= 1'b0;
      user_overflow   <= 1'b0;
    end else begin
      user_data_valid <= send;  // one cycle per frame
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        fill_cnt <= fill_cnt + 1'b1;
      end else if (pop && !push) begin
        fill_cnt <= fill_cnt - 1'b1;
      end
      if (drop) begin
        user_overflow <= 1'b1;  // sticky until reset
      end
      // returned credit beyond the receiver's slots is ignored
      if (user_credit && (credits_left != CREDIT_MAX)) begin
        credits <= credits_left + 1'b1;
      end else begin
        credits <= credits_left;
      end
    end
  end

  assign {user_sync, user_overrange, user_q, user_q_d, user_i, user_i_d} = frame_q;

endmodule

/* rtl/adc_pkg.sv */
/*
 * ADC capture package
 * sample and lane word widths, frame buffer sizing, credit count
 * and the deserializer state encoding, shared by the capture path
 */

package adc_pkg;

  // ------------------------------------------------
  // sample and word geometry
  // ------------------------------------------------
  localparam int SAMPLE_W     = 8;  // bits per adc sample
  localparam int DESER_FACTOR = 4;  // samples per lane per word, also sync bits per frame
  localparam int NUM_LANES    = 4;  // i, i delayed, q, q delayed
  localparam int OVR_GROUPS   = 2;  // one over-range bit per half word
  localparam int SLOT_W       = $clog2(DESER_FACTOR);

  // ------------------------------------------------
  // frame buffer sizing
  // ------------------------------------------------
  localparam int FIFO_DEPTH  = 8;  // frames held
  localparam int CREDIT_INIT = 4;  // receiver slots, credits after reset
  localparam int PTR_W       = $clog2(FIFO_DEPTH);
  localparam int CNT_W       = $clog2(FIFO_DEPTH + 1);  // fill level incl. full
  localparam int CREDIT_W    = $clog2(CREDIT_INIT + 1);

  // four lane words plus sync and over-range status, 134 bits
  localparam int FRAME_W = NUM_LANES * DESER_FACTOR * SAMPLE_W + DESER_FACTOR + OVR_GROUPS;

  // ------------------------------------------------
  // types
  // ------------------------------------------------
  typedef logic [SAMPLE_W-1:0] sample_t;

  // slot 0 sits in the low byte
  typedef logic [DESER_FACTOR*SAMPLE_W-1:0] lane_word_t;

  typedef enum logic [0:0] {
    DESER_ALIGN = 1'b0,  // waiting for first sync
    DESER_RUN   = 1'b1   // framing words
  } deser_state_t;

endpackage

/* rtl/adc_sample_deser.sv */
/*
 * ADC sample deserializer
 * collects the four sample lanes 1:4 into lane words, with the word
 * boundary locked to the first sync pulse after reset
 */
`timescale 1ns/10ps

module adc_sample_deser (
  input  logic                adc_clk,
  input  logic                dcm_reset,
  input  adc_pkg::sample_t    adc_di,
  input  adc_pkg::sample_t    adc_di_d,
  input  adc_pkg::sample_t    adc_dq,
  input  adc_pkg::sample_t    adc_dq_d,
  input  logic                adc_sync,
  output adc_pkg::lane_word_t i_word,
  output adc_pkg::lane_word_t i_d_word,
  output adc_pkg::lane_word_t q_word,
  output adc_pkg::lane_word_t q_d_word,
  output logic                word_valid,
  output logic                slot_last
);
  import adc_pkg::*;

  localparam int PART_W = (DESER_FACTOR - 1) * SAMPLE_W;  // slots 0..2 in flight
  localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(DESER_FACTOR - 1);

  deser_state_t      state;
  logic [SLOT_W-1:0] slot_cnt;   // slot of the next sample
  sample_t           lane_in   [NUM_LANES];
  logic [PART_W-1:0] part_sr   [NUM_LANES];
  lane_word_t        lane_word [NUM_LANES];

  // lane order i, i_d, q, q_d
  assign lane_in[0] = adc_di;
  assign lane_in[1] = adc_di_d;
  assign lane_in[2] = adc_dq;
  assign lane_in[3] = adc_dq_d;

  // ------------------------------------------------
  // alignment and slot counting
  // ------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      state      <= DESER_ALIGN;
      slot_cnt   <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;  // strobe
      case (state)
        DESER_ALIGN: begin
          // sample under sync is slot 0, next one is slot 1
          if (adc_sync) begin
            state    <= DESER_RUN;
            slot_cnt <= SLOT_W'(1);
          end
        end
        default: begin
          slot_cnt <= slot_cnt + 1'b1;  // wraps 3 -> 0
          if (slot_cnt == LAST_SLOT) begin
            word_valid <= 1'b1;  // word complete at this edge
          end
        end
      endcase
    end
  end

  // slot-3 sample is being taken this cycle
  assign slot_last = (state == DESER_RUN) && (slot_cnt == LAST_SLOT);

  // ------------------------------------------------
  // lane shift registers
  // ------------------------------------------------
  always_ff @(posedge adc_clk) begin
    for (int ln = 0; ln < NUM_LANES; ln++) begin
      // newest sample enters at the top, slot 0 ends up lowest
      part_sr[ln] <= {lane_in[ln], part_sr[ln][PART_W-1:SAMPLE_W]};
      if (slot_last) begin
        lane_word[ln] <= {lane_in[ln], part_sr[ln]};  // held until next word
      end
    end
  end

  assign i_word   = lane_word[0];
  assign i_d_word = lane_word[1];
  assign q_word   = lane_word[2];
  assign q_d_word = lane_word[3];

endmodule

/* rtl/adc_status_capture.sv */
/*
 * ADC status capture
 * per-slot sync bits and half-word over-range flags, closed on the
 * slot-3 sample and held for the frame buffer
 */
`timescale 1ns/10ps

module adc_status_capture (
  input  logic                             adc_clk,
  input  logic                             dcm_reset,
  input  logic                             adc_sync,
  input  logic                             adc_overrange,
  input  logic                             slot_last,
  output logic [adc_pkg::DESER_FACTOR-1:0] sync_bits,
  output logic [adc_pkg::OVR_GROUPS-1:0]   ovr_bits
);
  import adc_pkg::*;

  localparam int HIST_W = DESER_FACTOR - 1;  // slots before the last one

  logic [HIST_W-1:0] sync_hist;  // bit j = slot j of the open word
  logic [HIST_W-1:0] ovr_hist;

  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      sync_hist <= '0;
      ovr_hist  <= '0;
      sync_bits <= '0;
      ovr_bits  <= '0;
    end else begin
      sync_hist <= {adc_sync, sync_hist[HIST_W-1:1]};
      ovr_hist  <= {adc_overrange, ovr_hist[HIST_W-1:1]};
      // close the word on the slot-3 sample
      if (slot_last) begin
        sync_bits <= {adc_sync, sync_hist};
        // upper half is slots 2,3, lower half slots 0,1
        ovr_bits  <= {adc_overrange | ovr_hist[2], ovr_hist[1] | ovr_hist[0]};
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/bash
# build and run the ADC capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_adc_capture \
  -o sim_adc_capture > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_adc_capture > sim.log 2>&1 || echo "simulator returned an error"

grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
